// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tbInstrDecode
FILELIST = vlog.f
OBJDIR   = obj_dir
LOG      = sim.log

SOURCES  = $(shell grep -v '^+' $(FILELIST))
BIN      = $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^TESTBENCH PASSED$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== branchResolve.sv ====
`timescale 1ns/1ps
`default_nettype none

/*
 * Branch condition and next fetch address
 */
module branchResolve (
  input  idPkg::fetchPkt_t             fetch,
  input  idPkg::ctrl_t                 ctrl,
  input  logic [idPkg::DataWidth-1:0]  fwdA,
  input  logic [idPkg::DataWidth-1:0]  fwdB,
  input  logic [idPkg::DataWidth-1:0]  imm,
  output logic                         takenBranch,
  output logic [idPkg::DataWidth-1:0]  nextPc
);
  import idPkg::*;

  logic condMet;

  always_comb begin
    case (fetch.instr[31:26])
      OpBeq:    condMet = (fwdA == fwdB);
      OpBne:    condMet = (fwdA != fwdB);
      OpBlez:   condMet = ($signed(fwdA) <= 0);
      OpBgtz:   condMet = ($signed(fwdA) > 0);
      OpRegImm: condMet = fetch.instr[16] ? !fwdA[31] : fwdA[31];  // bgez / bltz
      default:  condMet = 1'b0;
    endcase
  end

  assign takenBranch = ctrl.branch && condMet;

  always_comb begin
    if (ctrl.jumpReg) begin
      nextPc = fwdA;
    end else if (ctrl.jump) begin
      nextPc = {fetch.cia[31:28], fetch.instr[25:0], 2'b00};  // Region of this instr
    end else if (takenBranch) begin
      nextPc = fetch.pca + (imm << 2);
    end else begin
      nextPc = fetch.pca;
    end
  end

endmodule

`default_nettype wire

// ==== idDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

/*
 * Decode control: instruction word to control fields, plus the syscall bubble sequencer
 */
module idDecoder (
  input  logic                        CLK,
  input  logic                        RESET,
  input  logic                        FREEZE,
  input  logic [idPkg::DataWidth-1:0] instr,
  output idPkg::ctrl_t                ctrl,
  output logic                        bubble,
  output logic                        sysOut
);
  import idPkg::*;

  localparam ctrl_t IllegalCtrl = '{illegal: 1'b1, aluOp: AluNop, default: 1'b0};

  logic [1:0] sysCount;  // Bubbles still owed to the held syscall

  // Common shape of every rt-writing immediate op
  function automatic ctrl_t immCtrl(aluOp_t op, logic sext);
    ctrl_t c;
    c          = '0;
    c.aluSrc   = 1'b1;
    c.regWrite = 1'b1;
    c.signExt  = sext;
    c.aluOp    = op;
    return c;
  endfunction

  //////////////////////////////
  // Control table
  //////////////////////////////

  always_comb begin
    ctrl       = '0;
    ctrl.aluOp = AluNop;
    case (instr[31:26])
      OpSpecial: begin
        ctrl.regDst   = 1'b1;
        ctrl.regWrite = 1'b1;
        case (instr[5:0])
          FnSll, FnSllv: ctrl.aluOp = AluSll;  // EX tells shamt from rs by funct
          FnSrl, FnSrlv: ctrl.aluOp = AluSrl;
          FnSra, FnSrav: ctrl.aluOp = AluSra;
          FnAdd:         ctrl.aluOp = AluAdd;
          FnAddu:        ctrl.aluOp = AluAddU;
          FnSub:         ctrl.aluOp = AluSub;
          FnSubu:        ctrl.aluOp = AluSubU;
          FnAnd:         ctrl.aluOp = AluAnd;
          FnOr:          ctrl.aluOp = AluOr;
          FnXor:         ctrl.aluOp = AluXor;
          FnNor:         ctrl.aluOp = AluNor;
          FnSlt:         ctrl.aluOp = AluSlt;
          FnSltu:        ctrl.aluOp = AluSltU;
          FnJr: begin
            ctrl.regDst   = 1'b0;
            ctrl.regWrite = 1'b0;
            ctrl.jump     = 1'b1;
            ctrl.jumpReg  = 1'b1;
          end
          FnJalr: begin
            ctrl.link    = 1'b1;  // Return address lands in rd
            ctrl.jump    = 1'b1;
            ctrl.jumpReg = 1'b1;
            ctrl.aluOp   = AluAddU;
          end
          FnSyscall: begin
            ctrl.regDst   = 1'b0;
            ctrl.regWrite = 1'b0;
            ctrl.syscall  = 1'b1;
            ctrl.aluOp    = AluAdd;  // Passes r2 through to EX
          end
          default: ctrl = IllegalCtrl;
        endcase
      end
      OpRegImm: begin
        if (instr[20:17] == 4'b0000) begin  // bltz or bgez
          ctrl.branch  = 1'b1;
          ctrl.signExt = 1'b1;
        end else begin
          ctrl = IllegalCtrl;
        end
      end
      OpBeq, OpBne, OpBlez, OpBgtz: begin
        ctrl.branch  = 1'b1;
        ctrl.signExt = 1'b1;  // Offset is signed
      end
      OpJ: ctrl.jump = 1'b1;
      OpJal: begin
        ctrl.link     = 1'b1;
        ctrl.jump     = 1'b1;
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = AluAddU;
      end
      OpAddi:  ctrl = immCtrl(AluAdd, 1'b1);
      OpAddiu: ctrl = immCtrl(AluAddU, 1'b1);
      OpSlti:  ctrl = immCtrl(AluSlt, 1'b1);
      OpSltiu: ctrl = immCtrl(AluSltU, 1'b1);
      OpAndi:  ctrl = immCtrl(AluAnd, 1'b0);
      OpOri:   ctrl = immCtrl(AluOr, 1'b0);
      OpXori:  ctrl = immCtrl(AluXor, 1'b0);
      OpLui:   ctrl = immCtrl(AluLui, 1'b0);
      OpLb, OpLh, OpLw, OpLbu, OpLhu: begin
        ctrl          = immCtrl(AluAdd, 1'b1);
        ctrl.memRead  = 1'b1;
        ctrl.memToReg = 1'b1;
      end
      OpSb, OpSh, OpSw: begin
        ctrl          = immCtrl(AluAdd, 1'b1);
        ctrl.regWrite = 1'b0;
        ctrl.memWrite = 1'b1;
      end
      default: ctrl = IllegalCtrl;
    endcase
  end

  //////////////////////////////
  // Syscall bubble sequencer
  //////////////////////////////

  always_ff @(posedge CLK or negedge RESET) begin
    if (!RESET) begin
      sysCount <= SysBubbleCycles;
    end else if (!FREEZE) begin
      if (!ctrl.syscall || sysCount == 2'd0) begin
        sysCount <= SysBubbleCycles;  // Rearm for the next syscall
      end else begin
        sysCount <= sysCount - 2'd1;
      end
    end
  end

  assign bubble = ctrl.syscall && (sysCount != 2'd0);
  assign sysOut = ctrl.syscall && (sysCount == 2'd0);

  // The counter must never release and stall in one cycle
  assert property (@(posedge CLK) disable iff (!RESET) !(bubble && sysOut));

endmodule

`default_nettype wire

// ==== idPipeReg.sv ====
`timescale 1ns/1ps
`default_nettype none

/*
 * ID to EX pipe register, cleared by a bubble and held by FREEZE
 */
module idPipeReg (
  input  logic                        CLK,
  input  logic                        RESET,
  input  logic                        FREEZE,
  input  logic                        bubble,
  input  idPkg::fetchPkt_t            fetch,
  input  idPkg::ctrl_t                ctrl,
  input  logic [idPkg::DataWidth-1:0] readA,
  input  logic [idPkg::DataWidth-1:0] readB,
  input  logic [idPkg::DataWidth-1:0] readSys,
  input  logic [idPkg::DataWidth-1:0] fwdA,
  input  logic [idPkg::DataWidth-1:0] opB,
  input  logic [idPkg::DataWidth-1:0] imm,
  input  logic [idPkg::DataWidth-1:0] nextPc,
  input  logic                        takenBranch,
  output idPkg::exePkt_t              exePkt,
  output logic [idPkg::DataWidth-1:0] nextPcReg
);
  import idPkg::*;

  logic [RegAddrWidth-1:0] rs;
  logic [RegAddrWidth-1:0] rt;
  logic [RegAddrWidth-1:0] destReg;
  exePkt_t                 pktNext;

  assign rs = fetch.instr[25:21];
  assign rt = fetch.instr[20:16];

  always_comb begin
    if (ctrl.regDst) begin
      destReg = fetch.instr[15:11];
    end else if (ctrl.link) begin
      destReg = LinkReg;
    end else if (ctrl.syscall) begin
      destReg = '0;
    end else begin
      destReg = rt;
    end
  end

  always_comb begin
    pktNext.opA         = ctrl.link ? fetch.pca : (ctrl.syscall ? readSys : readA);
    pktNext.opB         = ctrl.link ? LinkOffset : (ctrl.syscall ? '0 : opB);
    pktNext.readDataB   = readB;
    pktNext.instr       = fetch.instr;
    pktNext.destReg     = destReg;
    pktNext.srcA        = (ctrl.link || ctrl.syscall) ? '0 : rs;
    pktNext.srcB        = (ctrl.aluSrc || ctrl.link || ctrl.syscall) ? '0 : rt;
    pktNext.shamt       = fetch.instr[10:6];
    pktNext.aluOp       = ctrl.aluOp;
    pktNext.aluSrc      = ctrl.aluSrc;
    pktNext.memRead     = ctrl.memRead;
    pktNext.memWrite    = ctrl.memWrite;
    pktNext.memToReg    = ctrl.memToReg;
    pktNext.doWriteback = ctrl.regWrite && (destReg != '0);
    pktNext.takenBranch = takenBranch;
    pktNext.illegal     = ctrl.illegal;
  end

  always_ff @(posedge CLK or negedge RESET) begin
    if (!RESET) begin
      exePkt    <= '0;
      nextPcReg <= '0;
    end else if (bubble) begin  // Wins over FREEZE
      exePkt    <= '0;
      nextPcReg <= '0;
    end else if (!FREEZE) begin
      exePkt    <= pktNext;
      nextPcReg <= nextPc;
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  assert property (@(posedge CLK) disable iff (!RESET) bubble |=> !exePkt.doWriteback);

  // Register jump target comes from the forwarded rs
  assert property (@(posedge CLK) disable iff (!RESET)
    (!bubble && !FREEZE && ctrl.jumpReg) |=> nextPcReg == $past(fwdA));

  // EX sees the extended immediate as operand B
  assert property (@(posedge CLK) disable iff (!RESET)
    (!bubble && !FREEZE && ctrl.aluSrc && !ctrl.link && !ctrl.syscall)
      |=> exePkt.opB == $past(imm));

endmodule

`default_nettype wire

// ==== idPkg.sv ====
`default_nettype none

/*
 * Shared widths, encodings and packet types of the instruction decode stage
 */
package idPkg;

  localparam int DataWidth    = 32;
  localparam int RegAddrWidth = 5;
  localparam int NumRegs      = 32;

  localparam logic [RegAddrWidth-1:0] LinkReg         = 5'd31;
  localparam logic [RegAddrWidth-1:0] SysArgReg       = 5'd2;
  localparam logic [1:0]              SysBubbleCycles = 2'd3;
  localparam logic [DataWidth-1:0]    LinkOffset      = 32'd4;  // Return address past the slot

  //////////////////////////////
  // Encodings
  //////////////////////////////

  typedef enum logic [5:0] {
    OpSpecial = 6'b000000,
    OpRegImm  = 6'b000001,  // bltz and bgez, picked by rt
    OpJ       = 6'b000010,
    OpJal     = 6'b000011,
    OpBeq     = 6'b000100,
    OpBne     = 6'b000101,
    OpBlez    = 6'b000110,
    OpBgtz    = 6'b000111,
    OpAddi    = 6'b001000,
    OpAddiu   = 6'b001001,
    OpSlti    = 6'b001010,
    OpSltiu   = 6'b001011,
    OpAndi    = 6'b001100,
    OpOri     = 6'b001101,
    OpXori    = 6'b001110,
    OpLui     = 6'b001111,
    OpLb      = 6'b100000,
    OpLh      = 6'b100001,
    OpLw      = 6'b100011,
    OpLbu     = 6'b100100,
    OpLhu     = 6'b100101,
    OpSb      = 6'b101000,
    OpSh      = 6'b101001,
    OpSw      = 6'b101011
  } opcode_t;

  typedef enum logic [5:0] {
    FnSll     = 6'b000000,
    FnSrl     = 6'b000010,
    FnSra     = 6'b000011,
    FnSllv    = 6'b000100,
    FnSrlv    = 6'b000110,
    FnSrav    = 6'b000111,
    FnJr      = 6'b001000,
    FnJalr    = 6'b001001,
    FnSyscall = 6'b001100,
    FnAdd     = 6'b100000,
    FnAddu    = 6'b100001,
    FnSub     = 6'b100010,
    FnSubu    = 6'b100011,
    FnAnd     = 6'b100100,
    FnOr      = 6'b100101,
    FnXor     = 6'b100110,
    FnNor     = 6'b100111,
    FnSlt     = 6'b101010,
    FnSltu    = 6'b101011
  } funct_t;

  typedef enum logic [5:0] {
    AluAdd, AluAddU, AluSub, AluSubU, AluAnd, AluOr, AluXor, AluNor,
    AluSlt, AluSltU, AluSll, AluSrl, AluSra, AluLui, AluNop
  } aluOp_t;

  //////////////////////////////
  // Packets
  //////////////////////////////

  typedef struct packed {
    logic [DataWidth-1:0] instr;
    logic [DataWidth-1:0] pca;  // Next sequential address
    logic [DataWidth-1:0] cia;  // Own address
  } fetchPkt_t;

  typedef struct packed {
    logic   link;
    logic   regDst;
    logic   jump;
    logic   jumpReg;
    logic   branch;
    logic   memRead;
    logic   memToReg;
    logic   memWrite;
    logic   aluSrc;
    logic   regWrite;
    logic   signExt;
    logic   syscall;
    logic   illegal;
    aluOp_t aluOp;
  } ctrl_t;

  typedef struct packed {
    logic                    valid;
    logic [RegAddrWidth-1:0] destReg;
    logic [DataWidth-1:0]    data;
  } bypass_t;

  typedef struct packed {
    logic                    valid;
    logic [RegAddrWidth-1:0] destReg;
    logic [DataWidth-1:0]    data;
  } wbPort_t;

  typedef struct packed {
    logic [DataWidth-1:0]    opA;
    logic [DataWidth-1:0]    opB;
    logic [DataWidth-1:0]    readDataB;
    logic [DataWidth-1:0]    instr;
    logic [RegAddrWidth-1:0] destReg;
    logic [RegAddrWidth-1:0] srcA;
    logic [RegAddrWidth-1:0] srcB;
    logic [RegAddrWidth-1:0] shamt;
    aluOp_t                  aluOp;
    logic                    aluSrc;
    logic                    memRead;
    logic                    memWrite;
    logic                    memToReg;
    logic                    doWriteback;
    logic                    takenBranch;
    logic                    illegal;
  } exePkt_t;

endpackage

`default_nettype wire

// ==== instrDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

/*
 * Instruction decode stage: decode, register read, bypass, branch resolve, pipe register
 */
module instrDecode (
  input  logic                        CLK,
  input  logic                        RESET,
  input  logic                        FREEZE,
  input  idPkg::fetchPkt_t            fetch,
  input  logic [idPkg::DataWidth-1:0] aluResult,
  input  idPkg::bypass_t              memBypass,
  input  idPkg::bypass_t              wbBypass,
  input  idPkg::wbPort_t              wbWrite,
  output logic                        takenBranch,
  output logic                        bubble,
  output logic                        sysOut,
  output idPkg::exePkt_t              exePkt,
  output logic [idPkg::DataWidth-1:0] nextPcReg
);
  import idPkg::*;

  ctrl_t                ctrl;
  bypass_t              exBypass;
  logic [DataWidth-1:0] imm;
  logic [DataWidth-1:0] readA;
  logic [DataWidth-1:0] readB;
  logic [DataWidth-1:0] readSys;
  logic [DataWidth-1:0] fwdA;
  logic [DataWidth-1:0] fwdB;
  logic [DataWidth-1:0] opB;
  logic [DataWidth-1:0] nextPc;

  assign imm = ctrl.signExt ? {{16{fetch.instr[15]}}, fetch.instr[15:0]}
                            : {16'b0, fetch.instr[15:0]};

  // Instruction now in EX forwards its ALU result
  assign exBypass = '{valid: exePkt.doWriteback, destReg: exePkt.destReg, data: aluResult};

  idDecoder u_idDecoder (.CLK, .RESET, .FREEZE, .instr(fetch.instr), .ctrl, .bubble, .sysOut);

  regFile u_regFile (.CLK, .wbWrite, .srcA(fetch.instr[25:21]), .srcB(fetch.instr[20:16]),
                     .readA, .readB, .readSys);

  operandForward u_operandForward (.srcA(fetch.instr[25:21]), .srcB(fetch.instr[20:16]),
                                   .readA, .readB, .imm, .aluSrc(ctrl.aluSrc),
                                   .exBypass, .memBypass, .wbBypass, .fwdA, .fwdB, .opB);

  branchResolve u_branchResolve (.fetch, .ctrl, .fwdA, .fwdB, .imm, .takenBranch, .nextPc);

  idPipeReg u_idPipeReg (.CLK, .RESET, .FREEZE, .bubble, .fetch, .ctrl, .readA, .readB,
                         .readSys, .fwdA, .opB, .imm, .nextPc, .takenBranch,
                         .exePkt, .nextPcReg);

endmodule

`default_nettype wire

// ==== operandForward.sv ====
`timescale 1ns/1ps
`default_nettype none

/*
 * Operand bypass: EX over MEM over WB, else the register file value
 */
module operandForward (
  input  logic [idPkg::RegAddrWidth-1:0] srcA,
  input  logic [idPkg::RegAddrWidth-1:0] srcB,
  input  logic [idPkg::DataWidth-1:0]    readA,
  input  logic [idPkg::DataWidth-1:0]    readB,
  input  logic [idPkg::DataWidth-1:0]    imm,
  input  logic                           aluSrc,
  input  idPkg::bypass_t                 exBypass,
  input  idPkg::bypass_t                 memBypass,
  input  idPkg::bypass_t                 wbBypass,
  output logic [idPkg::DataWidth-1:0]    fwdA,
  output logic [idPkg::DataWidth-1:0]    fwdB,
  output logic [idPkg::DataWidth-1:0]    opB
);
  import idPkg::*;

  // Youngest matching producer wins
  function automatic logic [DataWidth-1:0] pick(
    logic [RegAddrWidth-1:0] src,
    logic [DataWidth-1:0]    fileVal
  );
    if (exBypass.valid && exBypass.destReg == src) begin
      return exBypass.data;
    end else if (memBypass.valid && memBypass.destReg == src) begin
      return memBypass.data;
    end else if (wbBypass.valid && wbBypass.destReg == src) begin
      return wbBypass.data;  // Covers a write landing this cycle
    end
    return fileVal;
  endfunction

  assign opB  = aluSrc ? imm : readB;  // Unforwarded value for EX
  assign fwdA = pick(srcA, readA);
  assign fwdB = pick(srcB, opB);

endmodule

`default_nettype wire

// ==== regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

/*
 * 32-entry register file, one write port and three read ports, r0 reads zero
 */
module regFile (
  input  logic                           CLK,
  input  idPkg::wbPort_t                 wbWrite,
  input  logic [idPkg::RegAddrWidth-1:0] srcA,
  input  logic [idPkg::RegAddrWidth-1:0] srcB,
  output logic [idPkg::DataWidth-1:0]    readA,
  output logic [idPkg::DataWidth-1:0]    readB,
  output logic [idPkg::DataWidth-1:0]    readSys
);
  import idPkg::*;

  logic [DataWidth-1:0] regs [NumRegs];

  always_ff @(posedge CLK) begin
    if (wbWrite.valid) begin
      regs[wbWrite.destReg] <= wbWrite.data;
    end
  end

  assign readA   = (srcA == '0) ? '0 : regs[srcA];
  assign readB   = (srcB == '0) ? '0 : regs[srcB];
  assign readSys = regs[SysArgReg];  // Syscall argument

  // Writeback filters r0 upstream
  assert property (@(posedge CLK) wbWrite.valid |-> wbWrite.destReg != '0);

endmodule

`default_nettype wire

// ==== tbInstrDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

/*
 * Testbench for the decode stage: fills the register file, walks a stimulus table
 * through a reference model, then runs the syscall bubble sequence
 */
module tbInstrDecode;
  import idPkg::*;

  localparam logic [31:0] Seed  = 32'h0819_b171;
  localparam bypass_t     NoByp = '0;
  localparam logic [5:0]  RFns [16] = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27,
                                        6'h2a, 6'h2b, 6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07};
  localparam logic [5:0]  MemOps [8] = '{6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2b};
  localparam aluOp_t      ImmAlu [8] = '{AluAdd, AluAddU, AluSlt, AluSltU,
                                         AluAnd, AluOr, AluXor, AluLui};  // By opcode[2:0]

  typedef struct {
    string       name;
    logic [31:0] instr;
    bypass_t     memB;
    bypass_t     wbB;  // Also drives the file write
    logic [31:0] aluRes;
    logic        freeze;
  } row_t;

  logic        CLK;
  logic        RESET;
  logic        FREEZE;
  fetchPkt_t   fetch;
  logic [31:0] aluResult;
  bypass_t     memBypass;
  bypass_t     wbBypass;
  wbPort_t     wbWrite;
  logic        takenBranch;
  logic        bubble;
  logic        sysOut;
  exePkt_t     exePkt;
  logic [31:0] nextPcReg;

  logic [31:0] lfsr;
  logic [31:0] shadow [32];  // Mirror of the register file
  row_t        rows [$];
  exePkt_t     expPkt;       // Model of the registered packet
  logic [31:0] expNext;
  int          errors;
  int          testsRun;
  int          testsFailed;

  instrDecode u_instrDecode (.CLK, .RESET, .FREEZE, .fetch, .aluResult, .memBypass, .wbBypass,
                             .wbWrite, .takenBranch, .bubble, .sysOut, .exePkt, .nextPcReg);

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] randBits(int n);
    logic [31:0] v;
    logic        fb;
    int          k;
    v = '0;
    for (k = 0; k < n; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [31:0] encR(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                       logic [4:0] sh, logic [5:0] fn);
    return {6'h00, rs, rt, rd, sh, fn};
  endfunction

  function automatic logic [31:0] encI(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                       logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] encJ(logic [5:0] op, logic [25:0] idx);
    return {op, idx};
  endfunction

  function automatic bypass_t byp(logic [4:0] dest, logic [31:0] val);
    bypass_t b;
    b.valid   = 1'b1;
    b.destReg = dest;
    b.data    = val;
    return b;
  endfunction

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic logic [31:0] pickSrc(logic [4:0] src, logic [31:0] fileVal,
                                          bypass_t exB, bypass_t memB, bypass_t wbB);
    if (exB.valid && exB.destReg == src) return exB.data;  // Youngest first
    if (memB.valid && memB.destReg == src) return memB.data;
    if (wbB.valid && wbB.destReg == src) return wbB.data;
    return fileVal;
  endfunction

  function automatic void refModel(input fetchPkt_t f, input bypass_t exB, input bypass_t memB,
                                   input bypass_t wbB, output exePkt_t p,
                                   output logic [31:0] npc, output logic taken);
    logic [5:0]  op;
    logic [4:0]  rs, rt, rd, dest;
    logic [31:0] imm, fileA, fileB, opB, fwdA, fwdB;
    logic        sext, immOp, regWr, regDst, link, jump, jumpReg, branch, sys, ill;
    logic        mRd, mWr, cond;
    aluOp_t      aop;
    op = f.instr[31:26];
    rs = f.instr[25:21];
    rt = f.instr[20:16];
    rd = f.instr[15:11];
    {sext, immOp, regWr, regDst, link, jump, jumpReg, branch, sys, ill, mRd, mWr} = '0;
    aop = AluNop;
    case (op)
      6'h00: begin
        regDst = 1'b1;
        regWr  = 1'b1;
        case (f.instr[5:0])
          6'h00, 6'h04: aop = AluSll;
          6'h02, 6'h06: aop = AluSrl;
          6'h03, 6'h07: aop = AluSra;
          6'h20: aop = AluAdd;
          6'h21: aop = AluAddU;
          6'h22: aop = AluSub;
          6'h23: aop = AluSubU;
          6'h24: aop = AluAnd;
          6'h25: aop = AluOr;
          6'h26: aop = AluXor;
          6'h27: aop = AluNor;
          6'h2a: aop = AluSlt;
          6'h2b: aop = AluSltU;
          6'h08: {regDst, regWr, jump, jumpReg} = 4'b0011;  // jr
          6'h09: begin  // jalr
            {link, jump, jumpReg} = 3'b111;
            aop = AluAddU;
          end
          6'h0c: begin  // syscall
            {regDst, regWr, sys} = 3'b001;
            aop = AluAdd;
          end
          default: {regDst, regWr, ill} = 3'b001;
        endcase
      end
      6'h01: begin
        if (rt[4:1] == 4'd0) {branch, sext} = 2'b11;
        else ill = 1'b1;
      end
      6'h02: jump = 1'b1;
      6'h03: begin
        {link, jump, regWr} = 3'b111;
        aop = AluAddU;
      end
      6'h04, 6'h05, 6'h06, 6'h07: {branch, sext} = 2'b11;
      6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
        immOp = 1'b1;
        sext  = (op[2] == 1'b0);  // Logical ops and lui zero-extend
        aop   = ImmAlu[op[2:0]];
      end
      6'h20, 6'h21, 6'h23, 6'h24, 6'h25: {immOp, sext, mRd} = 3'b111;
      6'h28, 6'h29, 6'h2b: {immOp, sext, mWr} = 3'b111;
      default: ill = 1'b1;
    endcase
    if (mRd || mWr) aop = AluAdd;  // Address add
    if (immOp) regWr = !mWr;
    imm   = sext ? {{16{f.instr[15]}}, f.instr[15:0]} : {16'h0, f.instr[15:0]};
    fileA = (rs == 5'd0) ? '0 : shadow[rs];
    fileB = (rt == 5'd0) ? '0 : shadow[rt];
    opB   = immOp ? imm : fileB;
    fwdA  = pickSrc(rs, fileA, exB, memB, wbB);
    fwdB  = pickSrc(rt, opB, exB, memB, wbB);
    case (op)
      6'h04:   cond = (fwdA == fwdB);
      6'h05:   cond = (fwdA != fwdB);
      6'h06:   cond = fwdA[31] || (fwdA == '0);
      6'h07:   cond = !fwdA[31] && (fwdA != '0);
      6'h01:   cond = rt[0] ? !fwdA[31] : fwdA[31];  // bgez, bltz
      default: cond = 1'b0;
    endcase
    taken = branch && cond;
    if (jumpReg) npc = fwdA;
    else if (jump) npc = {f.cia[31:28], f.instr[25:0], 2'b00};
    else if (taken) npc = f.pca + (imm << 2);
    else npc = f.pca;
    dest = regDst ? rd : (link ? 5'd31 : (sys ? 5'd0 : rt));
    p             = '0;
    p.opA         = link ? f.pca : (sys ? shadow[2] : fileA);
    p.opB         = link ? 32'd4 : (sys ? 32'd0 : opB);
    p.readDataB   = fileB;
    p.instr       = f.instr;
    p.destReg     = dest;
    p.srcA        = (link || sys) ? 5'd0 : rs;
    p.srcB        = (immOp || link || sys) ? 5'd0 : rt;
    p.shamt       = f.instr[10:6];
    p.aluOp       = aop;
    p.aluSrc      = immOp;
    p.memRead     = mRd;
    p.memWrite    = mWr;
    p.memToReg    = mRd;
    p.doWriteback = regWr && (dest != 5'd0);
    p.takenBranch = taken;
    p.illegal     = ill;
  endfunction

  //////////////////////////////
  // Checks and stimulus
  //////////////////////////////

  task automatic checkVal(string what, logic [191:0] got, logic [191:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  function automatic void finishTest(string name, int errBefore);
    testsRun++;
    if (errors != errBefore) testsFailed++;
    $display("%-12s %s", name, (errors == errBefore) ? "ok" : "bad");
  endfunction

  function automatic void addRow(string name, logic [31:0] instr, bypass_t memB, bypass_t wbB,
                                 logic freeze);
    row_t r;
    r.name   = name;
    r.instr  = instr;
    r.memB   = memB;
    r.wbB    = wbB;
    r.freeze = freeze;
    r.aluRes = randBits(32);
    rows.push_back(r);
  endfunction

  function automatic void buildTable();
    int k;
    for (k = 0; k < 16; k++) addRow($sformatf("r-fn%02h", RFns[k]),
                                    encR(5'd4, 5'd5, 5'd3, 5'd7, RFns[k]), NoByp, NoByp, 1'b0);
    for (k = 0; k < 8; k++) addRow($sformatf("imm-op%02h", 6'h08 + k),
                                   encI(6'h08 + 6'(k), 5'd7, 5'd6, 16'h8123), NoByp, NoByp, 1'b0);
    for (k = 0; k < 8; k++) addRow($sformatf("mem-op%02h", MemOps[k]),
                                   encI(MemOps[k], 5'd7, 5'd6, 16'h8ff0), NoByp, NoByp, 1'b0);
    // Bypass priority on jr targets and a branch operand
    addRow("ex-setup", encR(5'd1, 5'd2, 5'd12, 5'd0, 6'h21), NoByp, NoByp, 1'b0);
    addRow("fwd-ex", encR(5'd12, 5'd0, 5'd0, 5'd0, 6'h08), byp(5'd12, randBits(32)),
           byp(5'd12, randBits(32)), 1'b0);
    addRow("fwd-mem", encR(5'd12, 5'd0, 5'd0, 5'd0, 6'h08), byp(5'd12, randBits(32)),
           byp(5'd12, randBits(32)), 1'b0);
    addRow("fwd-wb", encR(5'd13, 5'd0, 5'd0, 5'd0, 6'h08), NoByp, byp(5'd13, randBits(32)), 1'b0);
    addRow("wb-landed", encR(5'd13, 5'd0, 5'd0, 5'd0, 6'h08), NoByp, NoByp, 1'b0);
    addRow("fwd-b", encI(6'h04, 5'd10, 5'd14, 16'h0020), byp(5'd14, 32'd5), NoByp, 1'b0);
    // r8 = 0, r9 negative, r10 = r11 = 5
    addRow("beq-t", encI(6'h04, 5'd10, 5'd11, 16'h0010), NoByp, NoByp, 1'b0);
    addRow("beq-n", encI(6'h04, 5'd10, 5'd9, 16'h0010), NoByp, NoByp, 1'b0);
    addRow("bne-t", encI(6'h05, 5'd10, 5'd9, 16'hfff8), NoByp, NoByp, 1'b0);
    addRow("bne-n", encI(6'h05, 5'd10, 5'd11, 16'hfff8), NoByp, NoByp, 1'b0);
    addRow("blez-zero", encI(6'h06, 5'd8, 5'd0, 16'h0040), NoByp, NoByp, 1'b0);
    addRow("blez-neg", encI(6'h06, 5'd9, 5'd0, 16'hff00), NoByp, NoByp, 1'b0);
    addRow("blez-n", encI(6'h06, 5'd10, 5'd0, 16'h0040), NoByp, NoByp, 1'b0);
    addRow("bgtz-t", encI(6'h07, 5'd10, 5'd0, 16'h0004), NoByp, NoByp, 1'b0);
    addRow("bgtz-n", encI(6'h07, 5'd8, 5'd0, 16'h0004), NoByp, NoByp, 1'b0);
    addRow("bltz-t", encI(6'h01, 5'd9, 5'd0, 16'hfffc), NoByp, NoByp, 1'b0);
    addRow("bltz-n", encI(6'h01, 5'd8, 5'd0, 16'hfffc), NoByp, NoByp, 1'b0);
    addRow("bgez-t", encI(6'h01, 5'd8, 5'd1, 16'h0100), NoByp, NoByp, 1'b0);
    addRow("bgez-n", encI(6'h01, 5'd9, 5'd1, 16'h0100), NoByp, NoByp, 1'b0);
    addRow("j", encJ(6'h02, 26'h0123456), NoByp, NoByp, 1'b0);
    addRow("jal", encJ(6'h03, 26'h2abcdef), NoByp, NoByp, 1'b0);
    addRow("jr", encR(5'd11, 5'd0, 5'd0, 5'd0, 6'h08), NoByp, NoByp, 1'b0);
    addRow("jalr", encR(5'd10, 5'd0, 5'd20, 5'd0, 6'h09), NoByp, NoByp, 1'b0);
    addRow("jalr-r0", encR(5'd10, 5'd0, 5'd0, 5'd0, 6'h09), NoByp, NoByp, 1'b0);
    addRow("addu-r0", encR(5'd4, 5'd5, 5'd0, 5'd0, 6'h21), NoByp, NoByp, 1'b0);
    addRow("pre-freeze", encR(5'd4, 5'd5, 5'd3, 5'd0, 6'h21), NoByp, NoByp, 1'b0);
    addRow("freeze-ori", encI(6'h0d, 5'd7, 5'd6, 16'h00ff), NoByp, NoByp, 1'b1);
    addRow("freeze-lw", encI(6'h23, 5'd7, 5'd6, 16'h0010), NoByp, NoByp, 1'b1);
    addRow("freeze-beq", encI(6'h04, 5'd10, 5'd11, 16'h0008), NoByp, NoByp, 1'b1);
    addRow("ill-op", encI(6'h3f, 5'd4, 5'd5, 16'h1234), NoByp, NoByp, 1'b0);
    addRow("ill-fn", encR(5'd4, 5'd5, 5'd3, 5'd0, 6'h3f), NoByp, NoByp, 1'b0);
    addRow("ill-regimm", encI(6'h01, 5'd9, 5'd2, 16'h0004), NoByp, NoByp, 1'b0);
  endfunction

  // Entered and left 5 ns after a rising edge
  task automatic writeReg(logic [4:0] r, logic [31:0] v);
    wbWrite.valid   = 1'b1;
    wbWrite.destReg = r;
    wbWrite.data    = v;
    @(posedge CLK);
    shadow[r] = v;
    #5;
  endtask

  task automatic applyRow(row_t r, int idx);
    fetchPkt_t   f;
    bypass_t     exB;
    exePkt_t     p;
    logic [31:0] npc;
    logic        tk;
    int          errBefore;
    errBefore   = errors;
    f.instr     = r.instr;
    f.cia       = 32'hA000_0400 + 32'(idx * 4);
    f.pca       = f.cia + 32'd4;
    exB.valid   = expPkt.doWriteback;  // Packet now in EX
    exB.destReg = expPkt.destReg;
    exB.data    = r.aluRes;
    refModel(f, exB, r.memB, r.wbB, p, npc, tk);
    fetch     = f;
    aluResult = r.aluRes;
    memBypass = r.memB;
    wbBypass  = r.wbB;
    wbWrite   = wbPort_t'(r.wbB);
    FREEZE    = r.freeze;
    #40;
    checkVal($sformatf("%s takenBranch", r.name), takenBranch, tk);
    checkVal($sformatf("%s bubble", r.name), bubble, 1'b0);
    @(posedge CLK);
    if (r.wbB.valid) shadow[r.wbB.destReg] = r.wbB.data;
    if (!r.freeze) begin
      expPkt  = p;
      expNext = npc;
    end
    #1;
    checkVal($sformatf("%s exePkt", r.name), exePkt, expPkt);
    checkVal($sformatf("%s nextPcReg", r.name), nextPcReg, expNext);
    finishTest(r.name, errBefore);
    #4;
  endtask

  task automatic runSyscall();
    fetchPkt_t   f;
    bypass_t     exB;
    exePkt_t     p;
    logic [31:0] npc;
    logic        tk;
    logic        released;
    int          errBefore;
    int          bubbles;
    int          n;
    errBefore = errors;
    bubbles   = 0;
    released  = 1'b0;
    f.instr   = encR(5'd0, 5'd0, 5'd0, 5'd0, 6'h0c);
    f.cia     = 32'hA000_0800;
    f.pca     = 32'hA000_0804;
    exB       = NoByp;
    refModel(f, exB, NoByp, NoByp, p, npc, tk);
    fetch     = f;
    aluResult = '0;
    memBypass = '0;
    wbBypass  = '0;
    wbWrite   = '0;
    FREEZE    = 1'b0;
    for (n = 0; n < 8 && !released; n++) begin
      #40;
      if (sysOut) begin
        released = 1'b1;
        checkVal("syscall bubble with sysOut", bubble, 1'b0);
      end else if (bubble) begin
        bubbles++;
      end else begin
        errors++;
        $display("Syscall held but neither bubble nor sysOut is high at %0t ns", $time);
      end
      @(posedge CLK);
      #1;
      if (released) begin
        checkVal("syscall exePkt", exePkt, p);  // opA carries r2
        checkVal("syscall nextPcReg", nextPcReg, npc);
      end else begin
        checkVal("bubble exePkt", exePkt, '0);
        checkVal("bubble nextPcReg", nextPcReg, '0);
      end
      #4;
    end
    if (!released) begin
      errors++;
      $display("Timed out waiting for sysOut while a syscall was held");
    end
    checkVal("syscall bubble count", bubbles, 3);
    finishTest("syscall", errBefore);
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    int   i;
    int   errBefore;
    logic tkFill;
    lfsr        = Seed;
    errors      = 0;
    testsRun    = 0;
    testsFailed = 0;
    RESET       = 1'b0;
    FREEZE      = 1'b0;
    fetch       = '0;
    aluResult   = '0;
    memBypass   = '0;
    wbBypass    = '0;
    wbWrite     = '0;
    for (i = 0; i < 32; i++) shadow[i] = '0;
    repeat (3) @(posedge CLK);
    #5;
    RESET     = 1'b1;
    errBefore = errors;
    checkVal("reset exePkt", exePkt, '0);
    checkVal("reset nextPcReg", nextPcReg, '0);
    checkVal("reset bubble", bubble, 1'b0);
    finishTest("reset", errBefore);

    for (i = 1; i < 32; i++) writeReg(5'(i), randBits(32));
    writeReg(5'd8, 32'd0);  // Branch operands
    writeReg(5'd9, 32'h8000_0010);
    writeReg(5'd10, 32'd5);
    writeReg(5'd11, 32'd5);
    wbWrite   = '0;
    errBefore = errors;
    refModel(fetch, NoByp, NoByp, NoByp, expPkt, expNext, tkFill);  // Fill ran on a nop
    checkVal("fill exePkt", exePkt, expPkt);
    finishTest("fill", errBefore);

    buildTable();
    foreach (rows[k]) applyRow(rows[k], k);
    runSyscall();

    $display("Tests %0d, failed %0d, check errors %0d", testsRun, testsFailed, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
idPkg.sv
idDecoder.sv
regFile.sv
operandForward.sv
branchResolve.sv
idPipeReg.sv
instrDecode.sv
tbInstrDecode.sv
